// File: all.f
+incdir+design
design/lc3b_pkg.sv
design/bus_watchdog.sv
design/regfile.sv
design/cpu_control.sv
design/datapath.sv
design/cpu.sv
verification/cpu_props.sv
verification/cpu_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check $(LOG) for the pass line"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

test: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "test passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verification/cpu_tb.sv
`timescale 1ns/1ns
`include "lc3b_consts.svh"

module cpu_tb;

logic                   clk;
logic                   rst_n;
logic                   imem_stb;
logic [`WORD_WIDTH-1:0] imem_adr;
logic [`WORD_WIDTH-1:0] imem_rdata;
logic                   imem_ack;
logic                   dmem_stb;
logic                   dmem_we;
logic [`WORD_WIDTH-1:0] dmem_adr;
logic [`WORD_WIDTH-1:0] dmem_wdata;
logic [`WORD_WIDTH-1:0] dmem_rdata;
logic                   dmem_ack;
logic                   halted;
logic                   bus_error;

logic [15:0] rom [64];
logic [15:0] ram [64];
logic [15:0] exp_adr [$];
logic [15:0] exp_dat [$];
int          seed = 32'h5720;
int          fetch_cnt;
int          n_exp;
int          i_left;
int          d_left;
bit          i_active;
bit          d_active;
bit          check_en;
bit          stall_en;
string       tname;

cpu UUT (.*);

initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
end

task automatic report_mismatch(input string name, input logic [15:0] exp, input logic [15:0] act);
    $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
    $display("test failed");
    $fatal(1);
endtask

task automatic report_error(input string what);
    $display("%s: %s", tname, what);
    $display("test failed");
    $fatal(1);
endtask

function automatic logic [15:0] ins(input logic [3:0] op, input logic [2:0] a,
                                    input logic [2:0] b, input logic [5:0] lo);
    return {op, a, b, lo};
endfunction

function automatic logic [5:0] imm(input int v);
    return {1'b1, v[4:0]};
endfunction

function automatic logic [15:0] br(input logic [2:0] nzp, input int off);
    return {4'b0000, nzp, off[8:0]};
endfunction

// preload depends on every address bit
function automatic logic [15:0] ram_fill(input int i);
    return 16'(i * 16'h9e37) ^ 16'h5a5a;
endfunction

// ***************************************************************************
// instruction-set reference model
// ***************************************************************************
function automatic int iss_run();
    logic [15:0] r [8];
    logic [15:0] m [64];
    logic [15:0] pc;
    logic [15:0] ir;
    logic [15:0] b;
    logic [15:0] v;
    logic [15:0] addr;
    logic [2:0]  cc;
    bit          wr;
    int          n;
    for (int i = 0; i < 8; i++) r[i] = '0;
    for (int i = 0; i < 64; i++) m[i] = ram_fill(i);
    cc = 3'b010;
    pc = '0;
    n  = 0;
    exp_adr.delete();
    exp_dat.delete();
    while (n < 1000) begin
        ir   = rom[pc[6:1]];
        pc   = pc + 16'd2;
        n++;
        b    = ir[5] ? {{11{ir[4]}}, ir[4:0]} : r[ir[2:0]];
        addr = r[ir[8:6]] + {{9{ir[5]}}, ir[5:0], 1'b0};
        wr   = 1'b1;
        case (ir[15:12])
            4'd1: v = r[ir[8:6]] + b;
            4'd5: v = r[ir[8:6]] & b;
            4'd9: v = ~r[ir[8:6]];
            4'd6: v = m[addr[6:1]];
            4'd7: begin
                wr = 1'b0;
                m[addr[6:1]] = r[ir[11:9]];
                exp_adr.push_back(addr);
                exp_dat.push_back(r[ir[11:9]]);
            end
            4'd0: begin
                wr = 1'b0;
                if (|(ir[11:9] & cc)) pc = pc + {{6{ir[8]}}, ir[8:0], 1'b0};
            end
            default: return n;   // trap and illegal
        endcase
        if (wr) begin
            r[ir[11:9]] = v;
            cc = {v[15], v == 16'd0, !v[15] && (v != 16'd0)};
        end
    end
    return n;
endfunction

task automatic load_program();
    // trap with the slot number as vector
    for (int i = 0; i < 64; i++) rom[i] = {8'hf0, 2'b00, 6'(i)};
    rom[0]  = ins(4'd1, 3'd1, 3'd0, imm(7));
    rom[1]  = ins(4'd1, 3'd2, 3'd0, imm(-3));
    rom[2]  = ins(4'd1, 3'd3, 3'd1, 6'd2);      // register form
    rom[3]  = ins(4'd5, 3'd4, 3'd1, imm(5));
    rom[4]  = ins(4'd5, 3'd5, 3'd1, 6'd2);
    rom[5]  = ins(4'd9, 3'd6, 3'd2, 6'h3f);
    rom[6]  = ins(4'd7, 3'd3, 3'd0, 6'd0);
    rom[7]  = ins(4'd7, 3'd4, 3'd0, 6'd1);
    rom[8]  = ins(4'd7, 3'd5, 3'd0, 6'd2);
    rom[9]  = ins(4'd7, 3'd6, 3'd0, 6'd3);
    rom[10] = ins(4'd1, 3'd7, 3'd1, 6'd1);
    rom[11] = ins(4'd1, 3'd7, 3'd7, 6'd7);      // base 28
    rom[12] = ins(4'd6, 3'd3, 3'd7, 6'd4);
    rom[13] = ins(4'd6, 3'd4, 3'd7, 6'h3e);     // offset -2
    rom[14] = ins(4'd1, 3'd3, 3'd3, imm(1));
    rom[15] = ins(4'd9, 3'd4, 3'd4, 6'h3f);
    rom[16] = ins(4'd7, 3'd3, 3'd7, 6'h3c);     // offset -4
    rom[17] = ins(4'd7, 3'd4, 3'd7, 6'd5);
    rom[18] = ins(4'd1, 3'd1, 3'd1, imm(-1));   // loop top
    rom[19] = ins(4'd7, 3'd1, 3'd7, 6'd6);
    rom[20] = br(3'b001, -3);
    rom[21] = br(3'b100, 5);
    rom[22] = br(3'b010, 2);
    rom[23] = ins(4'd7, 3'd2, 3'd0, 6'd7);
    rom[25] = br(3'b111, 1);
    rom[26] = ins(4'd7, 3'd2, 3'd0, 6'd8);
    rom[27] = ins(4'd1, 3'd5, 3'd2, imm(0));
    rom[28] = br(3'b011, 1);
    rom[29] = ins(4'd7, 3'd5, 3'd0, 6'd9);
    rom[30] = br(3'b110, 2);                    // skips 31 and 32
    rom[31] = ins(4'd7, 3'd2, 3'd0, 6'd10);
    rom[33] = br(3'b101, -3);                   // back to 31 then trap at 32
endtask

// ***************************************************************************
// memory models with random wait states
// ***************************************************************************
always @(posedge clk) begin
    imem_ack <= 1'b0;
    if (imem_stb && !imem_ack) begin
        if (!i_active) begin
            i_active = 1'b1;
            i_left   = $unsigned($random(seed)) % 4;
        end
        if (i_left == 0) begin
            imem_ack   <= 1'b1;
            imem_rdata <= rom[imem_adr[6:1]];
            i_active = 1'b0;
        end else begin
            i_left--;
        end
    end
end

always @(posedge clk) begin
    dmem_ack <= 1'b0;
    if (dmem_stb && !dmem_ack && !(stall_en && dmem_adr == 16'd0)) begin
        if (!d_active) begin
            d_active = 1'b1;
            d_left   = $unsigned($random(seed)) % 4;
        end
        if (d_left == 0) begin
            dmem_ack   <= 1'b1;
            dmem_rdata <= ram[dmem_adr[6:1]];
            if (dmem_we) ram[dmem_adr[6:1]] <= dmem_wdata;
            d_active = 1'b0;
        end else begin
            d_left--;
        end
    end
end

always @(posedge clk) begin
    if (imem_stb && imem_ack) fetch_cnt++;
end

// compare each acknowledged store with the model
always @(posedge clk) begin
    if (check_en && dmem_stb && dmem_ack && dmem_we) begin
        assert (exp_adr.size() > 0) else report_error("store beyond the expected list");
        assert (dmem_adr == exp_adr[0])
            else report_mismatch({tname, " adr"}, exp_adr[0], dmem_adr);
        assert (dmem_wdata == exp_dat[0])
            else report_mismatch({tname, " data"}, exp_dat[0], dmem_wdata);
        void'(exp_adr.pop_front());
        void'(exp_dat.pop_front());
    end
end

task automatic check_idle();
    assert (!imem_stb && !dmem_stb && !dmem_we && !halted && !bus_error)
        else report_error("bus or status output active around reset");
endtask

task automatic apply_reset();
    @(posedge clk) rst_n <= 1'b0;
    repeat (3) begin
        @(negedge clk);
        check_idle();
    end
    @(posedge clk) rst_n <= 1'b1;
    @(negedge clk);
    check_idle();   // cycle after reset
endtask

initial begin
    int cyc;
    rst_n      = 1'b0;
    imem_rdata = '0;
    imem_ack   = 1'b0;
    dmem_rdata = '0;
    dmem_ack   = 1'b0;
    check_en   = 1'b1;
    stall_en   = 1'b0;
    fetch_cnt  = 0;
    load_program();
    for (int i = 0; i < 64; i++) ram[i] = ram_fill(i);
    n_exp = iss_run();

    tname = "reset";
    apply_reset();
    fetch_cnt = 0;
    cyc = 0;
    while (!imem_stb && cyc < 10) begin
        @(negedge clk);
        cyc++;
    end
    assert (imem_stb) else report_error("no fetch after reset");
    assert (imem_adr == 16'd0) else report_mismatch(tname, 16'd0, imem_adr);

    tname = "program";
    cyc = 0;
    while (!halted && cyc < 3000) begin
        @(negedge clk);
        cyc++;
    end
    assert (halted) else report_error("core never halted");

    tname = "halt";
    assert (fetch_cnt == n_exp) else report_mismatch(tname, 16'(n_exp), 16'(fetch_cnt));
    assert (exp_adr.size() == 0) else report_error("expected stores never happened");
    repeat (10) begin
        @(negedge clk);
        assert (halted && !imem_stb && !dmem_stb) else report_error("bus active after halt");
    end

    tname    = "watchdog";
    check_en = 1'b0;
    stall_en = 1'b1;
    apply_reset();
    cyc = 0;
    while (!dmem_stb && cyc < 500) begin
        @(negedge clk);
        cyc++;
    end
    assert (dmem_stb) else report_error("stalled store never started");
    cyc = 0;
    while (!bus_error && cyc < `BUS_TIMEOUT + 4) begin
        @(negedge clk);
        cyc++;
    end
    assert (bus_error) else report_error("bus_error did not rise on a lost ack");
    assert (!dmem_stb && !halted) else report_error("strobe or halted high after bus error");

    $display("test passed");
    $finish;
end

endmodule : cpu_tb

// File: verification/cpu_props.sv
`timescale 1ns/1ns

module cpu_props (
    input logic        clk,
    input logic        rst_n,
    input logic        imem_stb,
    input logic [15:0] imem_adr,
    input logic        imem_ack,
    input logic        dmem_stb,
    input logic        dmem_we,
    input logic [15:0] dmem_adr,
    input logic [15:0] dmem_wdata,
    input logic        dmem_ack,
    input logic        halted,
    input logic        bus_error
);

// ***************************************************************************
// wishbone classic hold rules
// ***************************************************************************
imem_hold: assert property (@(posedge clk) disable iff (!rst_n)
    imem_stb && !imem_ack |=> bus_error || (imem_stb && $stable(imem_adr)))
    else $error("imem request changed before ack");

dmem_hold: assert property (@(posedge clk) disable iff (!rst_n)
    dmem_stb && !dmem_ack |=> bus_error ||
        (dmem_stb && $stable(dmem_adr) && $stable(dmem_we) && $stable(dmem_wdata)))
    else $error("dmem request changed before ack");

we_needs_stb: assert property (@(posedge clk) disable iff (!rst_n) dmem_we |-> dmem_stb)
    else $error("dmem_we high without dmem_stb");

// status and quiet bus after halt
halt_excl: assert property (@(posedge clk) disable iff (!rst_n) !(halted && bus_error))
    else $error("halted and bus_error both high");

halt_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    halted |-> !imem_stb && !dmem_stb)
    else $error("strobe raised while halted");

endmodule : cpu_props

bind cpu cpu_props props_i (.*);

// File: design/cpu.sv
`timescale 1ns/1ns
`include "lc3b_consts.svh"

module cpu (
    input  logic                   clk,
    input  logic                   rst_n,

    // instruction bus
    output logic                   imem_stb,
    output logic [`WORD_WIDTH-1:0] imem_adr,
    input  logic [`WORD_WIDTH-1:0] imem_rdata,
    input  logic                   imem_ack,

    // data bus
    output logic                   dmem_stb,
    output logic                   dmem_we,
    output logic [`WORD_WIDTH-1:0] dmem_adr,
    output logic [`WORD_WIDTH-1:0] dmem_wdata,
    input  logic [`WORD_WIDTH-1:0] dmem_rdata,
    input  logic                   dmem_ack,

    output logic                   halted,
    output logic                   bus_error
);

lc3b_pkg::lc3b_opcode opcode;
lc3b_pkg::alu_op      alu_sel;
logic                 branch_taken;
logic                 expired;
logic                 pc_load;
logic                 ir_load;
logic                 mar_load;
logic                 mdr_load;
logic                 reg_load;
logic                 cc_load;
logic                 pc_sel;

cpu_control _cpu_control (
    .clk,
    .rst_n,
    .opcode,
    .branch_taken,
    .imem_ack,
    .dmem_ack,
    .expired,
    .imem_stb,
    .dmem_stb,
    .dmem_we,
    .pc_load,
    .ir_load,
    .mar_load,
    .mdr_load,
    .reg_load,
    .cc_load,
    .alu_sel,
    .pc_sel,
    .halted,
    .bus_error
);

// one transfer at a time, so both buses share a timer
bus_watchdog _bus_watchdog (
    .clk,
    .rst_n,
    .busy(imem_stb | dmem_stb),
    .ack(imem_ack | dmem_ack),
    .expired
);

datapath _datapath (
    .clk,
    .rst_n,
    .pc_load,
    .ir_load,
    .mar_load,
    .mdr_load,
    .reg_load,
    .cc_load,
    .alu_sel,
    .pc_sel,
    .imem_rdata,
    .dmem_rdata,
    .opcode,
    .branch_taken,
    .imem_adr,
    .dmem_adr,
    .dmem_wdata
);

endmodule : cpu

// File: design/datapath.sv
`timescale 1ns/1ns
`include "lc3b_consts.svh"

module datapath (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   pc_load,
    input  logic                   ir_load,
    input  logic                   mar_load,
    input  logic                   mdr_load,
    input  logic                   reg_load,
    input  logic                   cc_load,
    input  lc3b_pkg::alu_op        alu_sel,
    input  logic                   pc_sel,
    input  logic [`WORD_WIDTH-1:0] imem_rdata,
    input  logic [`WORD_WIDTH-1:0] dmem_rdata,
    output lc3b_pkg::lc3b_opcode   opcode,
    output logic                   branch_taken,
    output logic [`WORD_WIDTH-1:0] imem_adr,
    output logic [`WORD_WIDTH-1:0] dmem_adr,
    output logic [`WORD_WIDTH-1:0] dmem_wdata
);

logic [`WORD_WIDTH-1:0] pc;
logic [`WORD_WIDTH-1:0] ir;
logic [`WORD_WIDTH-1:0] mar;
logic [`WORD_WIDTH-1:0] mdr;
logic [2:0]             cc;   // n z p
logic [2:0]             sr2;
logic [`WORD_WIDTH-1:0] sr1_data;
logic [`WORD_WIDTH-1:0] sr2_data;
logic [`WORD_WIDTH-1:0] imm5_sext;
logic [`WORD_WIDTH-1:0] offset6_x2;
logic [`WORD_WIDTH-1:0] pcoffset9_x2;
logic [`WORD_WIDTH-1:0] operand_b;
logic [`WORD_WIDTH-1:0] alu_out;

// ***************************************************************************
// decode and offsets
// ***************************************************************************
assign opcode       = lc3b_pkg::lc3b_opcode'(ir[15:12]);
assign imm5_sext    = {{(`WORD_WIDTH - 5){ir[4]}}, ir[4:0]};
assign offset6_x2   = {{(`WORD_WIDTH - 7){ir[5]}}, ir[5:0], 1'b0};
assign pcoffset9_x2 = {{(`WORD_WIDTH - 10){ir[8]}}, ir[8:0], 1'b0};

// str reads its source on port 2
assign sr2 = (opcode == lc3b_pkg::OP_STR) ? ir[11:9] : ir[2:0];

regfile _regfile (
    .clk,
    .rst_n,
    .load(reg_load),
    .dest(ir[11:9]),
    .data(mdr),
    .sr1(ir[8:6]),      // sr1 or base register
    .sr2,
    .sr1_data,
    .sr2_data
);

// ***************************************************************************
// alu
// ***************************************************************************
assign operand_b = ir[5] ? imm5_sext : sr2_data;

always_comb begin
    case (alu_sel)
        lc3b_pkg::ALU_ADD:  alu_out = sr1_data + operand_b;
        lc3b_pkg::ALU_AND:  alu_out = sr1_data & operand_b;
        lc3b_pkg::ALU_NOT:  alu_out = ~sr1_data;
        lc3b_pkg::ALU_PASS: alu_out = sr1_data;
    endcase
end

// ***************************************************************************
// registers
// ***************************************************************************
always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        pc <= '0;
        cc <= 3'b010;   // registers start at zero
    end else begin
        if (pc_load) begin
            // pc already points past the branch here
            pc <= pc_sel ? pc + pcoffset9_x2 : pc + `WORD_WIDTH'(2);
        end
        if (cc_load) begin
            cc <= {mdr[`WORD_WIDTH-1], mdr == '0, !mdr[`WORD_WIDTH-1] && (mdr != '0)};
        end
    end
end

always_ff @(posedge clk) begin
    if (ir_load) begin
        ir <= imem_rdata;
    end
    if (mar_load) begin
        mar <= sr1_data + offset6_x2;
    end
    if (mdr_load) begin
        mdr <= (opcode == lc3b_pkg::OP_LDR) ? dmem_rdata : alu_out;
    end
end

assign branch_taken = |(ir[11:9] & cc);
assign imem_adr     = pc;
assign dmem_adr     = mar;
assign dmem_wdata   = sr2_data;

endmodule : datapath

// File: design/cpu_control.sv
`timescale 1ns/1ns

module cpu_control (
    input  logic                 clk,
    input  logic                 rst_n,
    input  lc3b_pkg::lc3b_opcode opcode,
    input  logic                 branch_taken,
    input  logic                 imem_ack,
    input  logic                 dmem_ack,
    input  logic                 expired,
    output logic                 imem_stb,
    output logic                 dmem_stb,
    output logic                 dmem_we,
    output logic                 pc_load,
    output logic                 ir_load,
    output logic                 mar_load,
    output logic                 mdr_load,
    output logic                 reg_load,
    output logic                 cc_load,
    output lc3b_pkg::alu_op      alu_sel,
    output logic                 pc_sel,
    output logic                 halted,
    output logic                 bus_error
);

lc3b_pkg::cpu_state state;
lc3b_pkg::cpu_state state_next;

// ***************************************************************************
// state and bus strobes
// ***************************************************************************
// strobes are registered from the next state so they drop with the
// cycle after ack and stay low while reset is held
always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        state    <= lc3b_pkg::FETCH;
        imem_stb <= 1'b0;
        dmem_stb <= 1'b0;
        dmem_we  <= 1'b0;
    end else begin
        state    <= state_next;
        imem_stb <= (state_next == lc3b_pkg::FETCH);
        dmem_stb <= (state_next == lc3b_pkg::MEM_ACCESS);
        dmem_we  <= (state_next == lc3b_pkg::MEM_ACCESS) && (opcode == lc3b_pkg::OP_STR);
    end
end

// ***************************************************************************
// next state and datapath enables
// ***************************************************************************
always_comb begin
    state_next = state;
    pc_load    = 1'b0;
    ir_load    = 1'b0;
    mar_load   = 1'b0;
    mdr_load   = 1'b0;
    reg_load   = 1'b0;
    cc_load    = 1'b0;
    pc_sel     = 1'b0;   // pc + 2

    unique case (state)
        lc3b_pkg::FETCH: begin
            if (expired) begin
                state_next = lc3b_pkg::BUS_ERROR;
            end else if (imem_ack) begin
                ir_load    = 1'b1;
                pc_load    = 1'b1;
                state_next = lc3b_pkg::DECODE;
            end
        end
        lc3b_pkg::DECODE: begin
            case (opcode)
                lc3b_pkg::OP_BR, lc3b_pkg::OP_ADD, lc3b_pkg::OP_AND, lc3b_pkg::OP_NOT,
                lc3b_pkg::OP_LDR, lc3b_pkg::OP_STR: state_next = lc3b_pkg::EXECUTE;
                default: state_next = lc3b_pkg::HALT;   // trap and illegal
            endcase
        end
        lc3b_pkg::EXECUTE: begin
            case (opcode)
                lc3b_pkg::OP_BR: begin
                    pc_sel     = 1'b1;
                    pc_load    = branch_taken;
                    state_next = lc3b_pkg::FETCH;
                end
                lc3b_pkg::OP_LDR, lc3b_pkg::OP_STR: begin
                    mar_load   = 1'b1;   // base + offset
                    state_next = lc3b_pkg::MEM_ACCESS;
                end
                default: begin
                    mdr_load   = 1'b1;   // alu result parked in mdr
                    state_next = lc3b_pkg::WRITEBACK;
                end
            endcase
        end
        lc3b_pkg::MEM_ACCESS: begin
            if (expired) begin
                state_next = lc3b_pkg::BUS_ERROR;
            end else if (dmem_ack) begin
                mdr_load   = (opcode == lc3b_pkg::OP_LDR);
                state_next = (opcode == lc3b_pkg::OP_LDR) ? lc3b_pkg::WRITEBACK
                                                         : lc3b_pkg::FETCH;
            end
        end
        lc3b_pkg::WRITEBACK: begin
            reg_load   = 1'b1;
            cc_load    = 1'b1;
            state_next = lc3b_pkg::FETCH;
        end
        lc3b_pkg::HALT, lc3b_pkg::BUS_ERROR: begin
            state_next = state;   // only reset leaves
        end
    endcase
end

always_comb begin
    case (opcode)
        lc3b_pkg::OP_ADD: alu_sel = lc3b_pkg::ALU_ADD;
        lc3b_pkg::OP_AND: alu_sel = lc3b_pkg::ALU_AND;
        lc3b_pkg::OP_NOT: alu_sel = lc3b_pkg::ALU_NOT;
        default:          alu_sel = lc3b_pkg::ALU_PASS;
    endcase
end

assign halted    = (state == lc3b_pkg::HALT);
assign bus_error = (state == lc3b_pkg::BUS_ERROR);

endmodule : cpu_control

// File: design/regfile.sv
`timescale 1ns/1ns
`include "lc3b_consts.svh"

module regfile (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   load,
    input  logic [2:0]             dest,
    input  logic [`WORD_WIDTH-1:0] data,
    input  logic [2:0]             sr1,
    input  logic [2:0]             sr2,
    output logic [`WORD_WIDTH-1:0] sr1_data,
    output logic [`WORD_WIDTH-1:0] sr2_data
);

logic [`WORD_WIDTH-1:0] regs [`REG_COUNT];

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        for (int i = 0; i < `REG_COUNT; i++) begin
            regs[i] <= '0;
        end
    end else if (load) begin
        regs[dest] <= data;
    end
end

// no bypass, a write shows up one cycle later
assign sr1_data = regs[sr1];
assign sr2_data = regs[sr2];

endmodule : regfile

// File: design/bus_watchdog.sv
`timescale 1ns/1ns
`include "lc3b_consts.svh"

module bus_watchdog (
    input  logic clk,
    input  logic rst_n,
    input  logic busy,      // some strobe is up
    input  logic ack,
    output logic expired
);

localparam int CNT_W = $clog2(`BUS_TIMEOUT);

logic [CNT_W-1:0] count;

// wait cycles already spent on the current transfer
always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        count <= '0;
    end else if (!busy || ack) begin
        count <= '0;
    end else if (count != CNT_W'(`BUS_TIMEOUT - 1)) begin
        count <= count + 1'b1;   // saturates, state leaves on expiry anyway
    end
end

// current cycle is the last one allowed without ack
assign expired = busy && !ack && (count == CNT_W'(`BUS_TIMEOUT - 1));

endmodule : bus_watchdog

// File: design/lc3b_pkg.sv
package lc3b_pkg;

// ***************************************************************************
// instruction opcodes, LC-3b encodings
// ***************************************************************************
typedef enum logic [3:0] {
    OP_BR   = 4'b0000,
    OP_ADD  = 4'b0001,
    OP_AND  = 4'b0101,
    OP_LDR  = 4'b0110,
    OP_STR  = 4'b0111,
    OP_NOT  = 4'b1001,
    OP_TRAP = 4'b1111   // anything unlisted ends up here too
} lc3b_opcode;

// controller states
typedef enum logic [2:0] {
    FETCH,
    DECODE,
    EXECUTE,
    MEM_ACCESS,
    WRITEBACK,
    HALT,       // after trap or illegal opcode
    BUS_ERROR   // watchdog fired
} cpu_state;

// alu function select
typedef enum logic [1:0] {
    ALU_ADD,
    ALU_AND,
    ALU_NOT,
    ALU_PASS
} alu_op;

endpackage : lc3b_pkg

// File: design/lc3b_consts.svh
`ifndef LC3B_CONSTS_SVH
`define LC3B_CONSTS_SVH

// data and address width, the ISA fixes it at one word
`define WORD_WIDTH 16

// architectural registers R0..R7
`define REG_COUNT 8

// wait cycles allowed before a transfer counts as lost
`define BUS_TIMEOUT 16

`endif
